// File: hdl/fm_pkg.sv
/* shared types, register addresses and store field encodings
   for the FM register write front end */
`default_nettype none

package fm_pkg;

	// host bus and queue words
	typedef logic [7:0] byte_t;
	typedef logic [1:0] port_t;
	typedef logic [9:0] qword_t;

	// channel 0..5, operator in offset order S1 S3 S2 S4
	typedef logic [2:0] ch_t;
	typedef logic [1:0] op_t;

	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [6:0]  tl_t;
	typedef logic [3:0]  mul_t;
	typedef logic [2:0]  alg_t;
	typedef logic [2:0]  fb_t;
	typedef logic [9:0]  tmra_t;
	typedef logic [7:0]  tmrb_t;
	typedef logic [2:0]  cen_lim_t;

	// divider limits, counter wraps at limit so ratio is limit+1
	localparam cen_lim_t CEN_LIM_RST = 3'd5;
	localparam cen_lim_t CEN_LIM_N3  = 3'd2;
	localparam cen_lim_t CEN_LIM_N2  = 3'd1;

	// global registers
	localparam byte_t REG_LFO    = 8'h22;
	localparam byte_t REG_CLKA1  = 8'h24;
	localparam byte_t REG_CLKA2  = 8'h25;
	localparam byte_t REG_CLKB   = 8'h26;
	localparam byte_t REG_TIMER  = 8'h27;
	localparam byte_t REG_KON    = 8'h28;
	localparam byte_t REG_CLK_N6 = 8'h2D;
	localparam byte_t REG_CLK_N3 = 8'h2E;
	localparam byte_t REG_CLK_N2 = 8'h2F;

	// store field bases
	localparam byte_t DT_MUL  = 8'h30;
	localparam byte_t TL      = 8'h40;
	localparam byte_t FNUM_LO = 8'hA0;
	localparam byte_t FNUM_HI = 8'hA4;
	localparam byte_t FB_ALG  = 8'hB0;

	localparam int QUEUE_DEPTH = 16;
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
	localparam int NUM_CH      = 6;
	localparam int NUM_OP      = 24;

	typedef enum logic [2:0] {FLD_MUL, FLD_TL, FLD_FLO, FLD_FHI, FLD_ALG} store_fld_e;
	typedef enum logic [1:0] {IDLE, POP, LATCH, APPLY} dec_state_e;

endpackage

`default_nettype wire

// File: hdl/fm_cen_div.sv
/* clock-enable divider, limit changes deferred to the next wrap */
`default_nettype none

module fm_cen_div (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             cen,
	input  wire fm_pkg::cen_lim_t lim_sel,
	input  wire logic             lim_load,
	output logic                  clk_en
);
	import fm_pkg::*;

	cen_lim_t cnt;
	cen_lim_t lim;
	cen_lim_t lim_pend;
	logic pend_vld;
	logic wrap;

	assign wrap = cnt == lim;
	assign clk_en = cen & wrap;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			lim <= CEN_LIM_RST;
			pend_vld <= 1'b0;
		end else begin
			if (cen) begin
				if (wrap) begin
					cnt <= '0;
					// pending select only switches in at the wrap
					if (pend_vld) begin
						lim <= lim_pend;
						pend_vld <= 1'b0;
					end
				end else begin
					cnt <= cnt + 3'd1;
				end
			end
			if (lim_load) begin
				pend_vld <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lim_load) begin
			lim_pend <= lim_sel;
		end
	end

	a_clk_en_single: assert property (@(posedge clk) disable iff (rst)
		clk_en |=> (!clk_en || lim == '0));

endmodule

`default_nettype wire

// File: hdl/fm_write_queue.sv
/* write strobe edge capture and 16-entry queue of port/data words */
`default_nettype none

module fm_write_queue (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          write,
	input  wire fm_pkg::port_t addr,
	input  wire fm_pkg::byte_t din,
	input  wire logic          pop,
	output fm_pkg::qword_t     q,
	output logic               empty
);
	import fm_pkg::*;

	qword_t mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0] count;
	logic write_d;
	logic push;
	logic full;
	logic push_ok;
	logic pop_ok;

	// one push per rising edge of the strobe
	assign push = write & ~write_d;
	assign full = count == (QPTR_W + 1)'(QUEUE_DEPTH);
	assign empty = count == '0;
	assign push_ok = push & ~full;
	assign pop_ok = pop & ~empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			write_d <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			write_d <= write;
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= {addr, din};
		end
	end

	// registered read, word valid the cycle after pop
	always_ff @(posedge clk) begin
		if (pop_ok) begin
			q <= mem[rd_ptr];
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(push && full));

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		!(pop && empty));

endmodule

`default_nettype wire

// File: hdl/fm_mmr_decode.sv
/* pop sequencing, register select, global registers, busy pacing
   and store write strobes */
`default_nettype none

module fm_mmr_decode (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           clk_en,
	input  wire logic           empty,
	input  wire fm_pkg::qword_t q,
	output logic                pop,
	output logic                busy,
	output logic                lfo_en,
	output logic [2:0]          lfo_freq,
	output fm_pkg::tmra_t       value_a,
	output fm_pkg::tmrb_t       value_b,
	output logic                load_a,
	output logic                load_b,
	output logic                en_irq_a,
	output logic                en_irq_b,
	output logic                clr_a,
	output logic                clr_b,
	output logic                keyon,
	output fm_pkg::ch_t         keyon_ch,
	output logic [3:0]          keyon_ops,
	output fm_pkg::cen_lim_t    lim_sel,
	output logic                lim_load,
	output logic                wr_en,
	output fm_pkg::store_fld_e  wr_fld,
	output fm_pkg::ch_t         wr_ch,
	output fm_pkg::op_t         wr_op,
	output fm_pkg::byte_t       wr_data
);
	import fm_pkg::*;

	dec_state_e state;
	qword_t word;
	byte_t sel;
	logic sel_bank;
	logic apply_data;
	logic store_hit;
	store_fld_e fld;

	// upper bank holds channels 3 to 5
	function automatic ch_t chan_of(input logic bank, input logic [1:0] low);
		return bank ? ch_t'(low) + ch_t'(3) : ch_t'(low);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			pop <= 1'b0;
		end else begin
			pop <= 1'b0;
			case (state)
				IDLE: if (!empty && !busy) begin
					pop <= 1'b1;
					state <= POP;
				end
				POP: state <= LATCH;
				LATCH: state <= APPLY;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LATCH) begin
			word <= q;
		end
	end

	// port bit 0 marks a data word
	assign apply_data = state == APPLY && word[8];

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			sel_bank <= 1'b0;
			busy <= 1'b0;
			{lfo_en, lfo_freq} <= 4'd0;
			value_a <= '0;
			value_b <= '0;
			{en_irq_b, en_irq_a} <= 2'd0;
		end else if (state == APPLY) begin
			if (!word[8]) begin
				sel <= word[7:0];
				sel_bank <= word[9];
			end else begin
				busy <= 1'b1;
				case (sel)
					REG_LFO: {lfo_en, lfo_freq} <= word[3:0];
					REG_CLKA1: value_a[9:2] <= word[7:0];
					REG_CLKA2: value_a[1:0] <= word[1:0];
					REG_CLKB: value_b <= word[7:0];
					REG_TIMER: {en_irq_b, en_irq_a} <= word[3:2];
					default: ;
				endcase
			end
		end else if (clk_en) begin
			busy <= 1'b0;
		end
	end

	// one-cycle global pulses
	assign load_a = apply_data && sel == REG_TIMER && word[0];
	assign load_b = apply_data && sel == REG_TIMER && word[1];
	assign clr_a = apply_data && sel == REG_TIMER && word[4];
	assign clr_b = apply_data && sel == REG_TIMER && word[5];
	assign keyon = apply_data && sel == REG_KON && word[1:0] != 2'b11;
	assign keyon_ch = chan_of(word[2], word[1:0]);
	assign keyon_ops = word[7:4];
	assign lim_load = apply_data
		&& (sel == REG_CLK_N6 || sel == REG_CLK_N3 || sel == REG_CLK_N2);

	always_comb begin
		case (sel)
			REG_CLK_N3: lim_sel = CEN_LIM_N3;
			REG_CLK_N2: lim_sel = CEN_LIM_N2;
			default: lim_sel = CEN_LIM_RST;
		endcase
	end

	// slot 3 of each channel group is unused
	always_comb begin
		store_hit = 1'b0;
		fld = FLD_MUL;
		if (sel[1:0] != 2'b11) begin
			if (sel[7:4] == DT_MUL[7:4]) begin
				store_hit = 1'b1;
				fld = FLD_MUL;
			end else if (sel[7:4] == TL[7:4]) begin
				store_hit = 1'b1;
				fld = FLD_TL;
			end else if (sel[7:2] == FNUM_LO[7:2]) begin
				store_hit = 1'b1;
				fld = FLD_FLO;
			end else if (sel[7:2] == FNUM_HI[7:2]) begin
				store_hit = 1'b1;
				fld = FLD_FHI;
			end else if (sel[7:2] == FB_ALG[7:2]) begin
				store_hit = 1'b1;
				fld = FLD_ALG;
			end
		end
	end

	assign wr_en = apply_data && store_hit;
	assign wr_fld = fld;
	assign wr_ch = chan_of(sel_bank, sel[1:0]);
	assign wr_op = sel[3:2];
	assign wr_data = word[7:0];

	a_wr_en_apply: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> state == APPLY && $past(state) == LATCH);

endmodule

`default_nettype wire

// File: hdl/fm_reg_store.sv
/* per-channel and per-operator register arrays, fnum high-byte latch
   and combinational readback */
`default_nettype none

module fm_reg_store (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               wr_en,
	input  wire fm_pkg::store_fld_e wr_fld,
	input  wire fm_pkg::ch_t        wr_ch,
	input  wire fm_pkg::op_t        wr_op,
	input  wire fm_pkg::byte_t      wr_data,
	input  wire fm_pkg::ch_t        rd_ch,
	input  wire fm_pkg::op_t        rd_op,
	output fm_pkg::fnum_t           rd_fnum,
	output fm_pkg::block_t          rd_block,
	output fm_pkg::alg_t            rd_alg,
	output fm_pkg::fb_t             rd_fb,
	output fm_pkg::tl_t             rd_tl,
	output fm_pkg::mul_t            rd_mul
);
	import fm_pkg::*;

	fnum_t fnum [NUM_CH];
	block_t blk [NUM_CH];
	// block in 5:3, fnum 10:8 in 2:0
	logic [5:0] fhi [NUM_CH];
	alg_t alg [NUM_CH];
	fb_t fb [NUM_CH];
	tl_t tl [NUM_OP];
	mul_t mul [NUM_OP];
	logic [4:0] wr_idx;
	logic [4:0] rd_idx;

	// four operator slots per channel
	assign wr_idx = {wr_ch, wr_op};
	assign rd_idx = {rd_ch, rd_op};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CH; i++) begin
				fnum[i] <= '0;
				blk[i] <= '0;
				fhi[i] <= '0;
				alg[i] <= '0;
				fb[i] <= '0;
			end
			for (int i = 0; i < NUM_OP; i++) begin
				tl[i] <= '0;
				mul[i] <= '0;
			end
		end else if (wr_en) begin
			case (wr_fld)
				FLD_MUL: mul[wr_idx] <= wr_data[3:0];
				FLD_TL: tl[wr_idx] <= wr_data[6:0];
				FLD_FHI: fhi[wr_ch] <= wr_data[5:0];
				// high byte lands together with the low byte
				FLD_FLO: {blk[wr_ch], fnum[wr_ch]} <= {fhi[wr_ch], wr_data};
				FLD_ALG: {fb[wr_ch], alg[wr_ch]} <= wr_data[5:0];
				default: ;
			endcase
		end
	end

	assign rd_fnum = fnum[rd_ch];
	assign rd_block = blk[rd_ch];
	assign rd_alg = alg[rd_ch];
	assign rd_fb = fb[rd_ch];
	assign rd_tl = tl[rd_idx];
	assign rd_mul = mul[rd_idx];

endmodule

`default_nettype wire

// File: hdl/fm_regs_top.sv
/* register front end top, queue to decode to store with the divider */
`default_nettype none

module fm_regs_top (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          cen,
	input  wire logic          write,
	input  wire fm_pkg::port_t addr,
	input  wire fm_pkg::byte_t din,
	input  wire fm_pkg::ch_t   rd_ch,
	input  wire fm_pkg::op_t   rd_op,
	output logic               busy,
	output logic               clk_en,
	output logic               lfo_en,
	output logic [2:0]         lfo_freq,
	output fm_pkg::tmra_t      value_a,
	output fm_pkg::tmrb_t      value_b,
	output logic               load_a,
	output logic               load_b,
	output logic               en_irq_a,
	output logic               en_irq_b,
	output logic               clr_a,
	output logic               clr_b,
	output logic               keyon,
	output fm_pkg::ch_t        keyon_ch,
	output logic [3:0]         keyon_ops,
	output fm_pkg::fnum_t      rd_fnum,
	output fm_pkg::block_t     rd_block,
	output fm_pkg::alg_t       rd_alg,
	output fm_pkg::fb_t        rd_fb,
	output fm_pkg::tl_t        rd_tl,
	output fm_pkg::mul_t       rd_mul
);
	import fm_pkg::*;

	qword_t q;
	logic empty;
	logic pop;
	cen_lim_t lim_sel;
	logic lim_load;
	logic wr_en;
	store_fld_e wr_fld;
	ch_t wr_ch;
	op_t wr_op;
	byte_t wr_data;

	fm_cen_div u_cen_div (
		.clk      (clk),
		.rst      (rst),
		.cen      (cen),
		.lim_sel  (lim_sel),
		.lim_load (lim_load),
		.clk_en   (clk_en)
	);

	fm_write_queue u_write_queue (
		.clk   (clk),
		.rst   (rst),
		.write (write),
		.addr  (addr),
		.din   (din),
		.pop   (pop),
		.q     (q),
		.empty (empty)
	);

	fm_mmr_decode u_mmr_decode (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.empty     (empty),
		.q         (q),
		.pop       (pop),
		.busy      (busy),
		.lfo_en    (lfo_en),
		.lfo_freq  (lfo_freq),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.en_irq_a  (en_irq_a),
		.en_irq_b  (en_irq_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.keyon     (keyon),
		.keyon_ch  (keyon_ch),
		.keyon_ops (keyon_ops),
		.lim_sel   (lim_sel),
		.lim_load  (lim_load),
		.wr_en     (wr_en),
		.wr_fld    (wr_fld),
		.wr_ch     (wr_ch),
		.wr_op     (wr_op),
		.wr_data   (wr_data)
	);

	fm_reg_store u_reg_store (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_fld   (wr_fld),
		.wr_ch    (wr_ch),
		.wr_op    (wr_op),
		.wr_data  (wr_data),
		.rd_ch    (rd_ch),
		.rd_op    (rd_op),
		.rd_fnum  (rd_fnum),
		.rd_block (rd_block),
		.rd_alg   (rd_alg),
		.rd_fb    (rd_fb),
		.rd_tl    (rd_tl),
		.rd_mul   (rd_mul)
	);

endmodule

`default_nettype wire

// File: dv/fm_regs_tb.sv
/* FM register front end testbench with a table of register writes,
   reference model of globals and store, burst and divider checks */
`default_nettype none

module fm_regs_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fm_pkg::*;

	typedef struct packed {
		logic  bank;
		byte_t regno;
		byte_t data;
		logic  wait_idle;
	} row_t;

	localparam int NUM_ROWS = 22;

	// bank, register, data, wait for idle
	row_t rows [NUM_ROWS] = '{
		{1'b0, REG_LFO,   8'h0B, 1'b1},
		{1'b0, REG_CLKA1, 8'h5A, 1'b0},
		{1'b0, REG_CLKA2, 8'h03, 1'b1},
		{1'b0, REG_CLKB,  8'hC3, 1'b1},
		{1'b0, REG_TIMER, 8'h0F, 1'b1},
		{1'b0, REG_TIMER, 8'h34, 1'b1},
		// high byte alone must not show on readback
		{1'b0, 8'hA4,     8'h2D, 1'b1},
		{1'b0, 8'hA0,     8'h9C, 1'b1},
		{1'b1, 8'hA6,     8'h1F, 1'b1},
		{1'b1, 8'hA2,     8'hE1, 1'b1},
		{1'b1, 8'hA5,     8'h3A, 1'b0},
		{1'b1, 8'hA1,     8'h47, 1'b1},
		{1'b0, REG_KON,   8'hF1, 1'b1},
		{1'b0, REG_KON,   8'h56, 1'b1},
		// channel codes 3 and 7 give no key-on
		{1'b0, REG_KON,   8'hA3, 1'b1},
		{1'b0, REG_KON,   8'h97, 1'b1},
		// unused slot 3 of each group
		{1'b0, 8'h43,     8'h7F, 1'b1},
		{1'b0, 8'hB3,     8'h3F, 1'b1},
		{1'b0, 8'hA7,     8'h3F, 1'b1},
		// low byte to channel 3 exposes a stray high byte
		{1'b1, 8'hA0,     8'h55, 1'b1},
		{1'b0, 8'hB1,     8'h2E, 1'b1},
		{1'b0, 8'h21,     8'hFF, 1'b1}
	};

	logic clk;
	logic rst;
	logic cen;
	logic write;
	port_t addr;
	byte_t din;
	ch_t rd_ch;
	op_t rd_op;
	logic busy;
	logic clk_en;
	logic lfo_en;
	logic [2:0] lfo_freq;
	tmra_t value_a;
	tmrb_t value_b;
	logic load_a;
	logic load_b;
	logic en_irq_a;
	logic en_irq_b;
	logic clr_a;
	logic clr_b;
	logic keyon;
	ch_t keyon_ch;
	logic [3:0] keyon_ops;
	fnum_t rd_fnum;
	block_t rd_block;
	alg_t rd_alg;
	fb_t rd_fb;
	tl_t rd_tl;
	mul_t rd_mul;

	// reference model state
	fnum_t exp_fnum [NUM_CH];
	block_t exp_blk [NUM_CH];
	logic [5:0] exp_fhi [NUM_CH];
	alg_t exp_alg [NUM_CH];
	fb_t exp_fb [NUM_CH];
	tl_t exp_tl [NUM_OP];
	mul_t exp_mul [NUM_OP];
	logic exp_lfo_en;
	logic [2:0] exp_lfo_freq;
	tmra_t exp_value_a;
	tmrb_t exp_value_b;
	logic exp_irq_a;
	logic exp_irq_b;
	int exp_ld_a;
	int exp_ld_b;
	int exp_clr_a;
	int exp_clr_b;
	int exp_kon_cnt;
	ch_t exp_kon_ch;
	logic [3:0] exp_kon_ops;

	// observed pulses and busy rises
	logic busy_q;
	int busy_rises;
	int ld_a_cnt;
	int ld_b_cnt;
	int clr_a_cnt;
	int clr_b_cnt;
	int kon_cnt;
	ch_t kon_ch_seen;
	logic [3:0] kon_ops_seen;

	int data_sent;
	int errors;
	int timeouts;
	int seed;

	fm_regs_top u_fm_regs_top (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.write     (write),
		.addr      (addr),
		.din       (din),
		.rd_ch     (rd_ch),
		.rd_op     (rd_op),
		.busy      (busy),
		.clk_en    (clk_en),
		.lfo_en    (lfo_en),
		.lfo_freq  (lfo_freq),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.en_irq_a  (en_irq_a),
		.en_irq_b  (en_irq_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.keyon     (keyon),
		.keyon_ch  (keyon_ch),
		.keyon_ops (keyon_ops),
		.rd_fnum   (rd_fnum),
		.rd_block  (rd_block),
		.rd_alg    (rd_alg),
		.rd_fb     (rd_fb),
		.rd_tl     (rd_tl),
		.rd_mul    (rd_mul)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			busy_rises <= 0;
			ld_a_cnt <= 0;
			ld_b_cnt <= 0;
			clr_a_cnt <= 0;
			clr_b_cnt <= 0;
			kon_cnt <= 0;
			kon_ch_seen <= '0;
			kon_ops_seen <= '0;
		end else begin
			busy_q <= busy;
			if (busy && !busy_q) begin
				busy_rises <= busy_rises + 1;
			end
			if (keyon) begin
				kon_cnt <= kon_cnt + 1;
				kon_ch_seen <= keyon_ch;
				kon_ops_seen <= keyon_ops;
			end
			ld_a_cnt <= ld_a_cnt + int'(load_a);
			ld_b_cnt <= ld_b_cnt + int'(load_b);
			clr_a_cnt <= clr_a_cnt + int'(clr_a);
			clr_b_cnt <= clr_b_cnt + int'(clr_b);
		end
	end

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_tmra(input string name, input tmra_t got, input tmra_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_fnum(input string name, input fnum_t got, input fnum_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_alg(input string name, input alg_t got, input alg_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_tl(input string name, input tl_t got, input tl_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// strobe drops for a cycle so the next edge is seen
	task automatic host_word(input port_t port, input byte_t data);
		@(posedge clk);
		#1;
		write = 1'b1;
		addr = port;
		din = data;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic apply_model(input logic bank, input byte_t regno, input byte_t data);
		int ch;
		int idx;
		ch = bank ? int'(regno[1:0]) + 3 : int'(regno[1:0]);
		idx = ch * 4 + int'(regno[3:2]);
		case (regno)
			REG_LFO: {exp_lfo_en, exp_lfo_freq} = data[3:0];
			REG_CLKA1: exp_value_a[9:2] = data;
			REG_CLKA2: exp_value_a[1:0] = data[1:0];
			REG_CLKB: exp_value_b = data;
			REG_TIMER: begin
				exp_ld_a += int'(data[0]);
				exp_ld_b += int'(data[1]);
				exp_irq_a = data[2];
				exp_irq_b = data[3];
				exp_clr_a += int'(data[4]);
				exp_clr_b += int'(data[5]);
			end
			REG_KON: if (data[1:0] != 2'b11) begin
				exp_kon_cnt++;
				exp_kon_ch = data[2] ? ch_t'(data[1:0]) + ch_t'(3) : ch_t'(data[1:0]);
				exp_kon_ops = data[7:4];
			end
			default: if (regno[1:0] != 2'b11) begin
				if ((regno & 8'hF0) == DT_MUL) begin
					exp_mul[idx] = data[3:0];
				end else if ((regno & 8'hF0) == TL) begin
					exp_tl[idx] = data[6:0];
				end else if ((regno & 8'hFC) == FNUM_HI) begin
					exp_fhi[ch] = data[5:0];
				end else if ((regno & 8'hFC) == FNUM_LO) begin
					// latched high byte commits with the low byte
					exp_blk[ch] = exp_fhi[ch][5:3];
					exp_fnum[ch] = {exp_fhi[ch][2:0], data};
				end else if ((regno & 8'hFC) == FB_ALG) begin
					exp_fb[ch] = data[5:3];
					exp_alg[ch] = data[2:0];
				end
			end
		endcase
	endtask

	task automatic issue_row(input logic bank, input byte_t regno, input byte_t data);
		host_word({bank, 1'b0}, regno);
		host_word({bank, 1'b1}, data);
		data_sent++;
		apply_model(bank, regno, data);
	endtask

	// every data word gives one busy pulse
	task automatic wait_idle();
		int limit;
		int n;
		limit = 200 + 40 * (data_sent - busy_rises);
		n = 0;
		@(negedge clk);
		while ((busy_rises != data_sent || busy) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (busy_rises != data_sent || busy) begin
			timeouts++;
			$display("timeout: DUT did not return to idle after %0d data writes", data_sent);
		end
	endtask

	task automatic measure_period(input byte_t expected);
		int n;
		n = 0;
		@(negedge clk);
		while (!clk_en && n < 32) begin
			@(negedge clk);
			n++;
		end
		if (!clk_en) begin
			timeouts++;
			$display("timeout: no clk_en pulse seen");
			return;
		end
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!clk_en && n < 32);
		if (!clk_en) begin
			timeouts++;
			$display("timeout: clk_en pulse did not repeat");
		end else begin
			check_byte("clk_en period", byte_t'(n), expected);
		end
	endtask

	task automatic check_globals();
		@(negedge clk);
		check_byte("lfo_en", byte_t'(lfo_en), byte_t'(exp_lfo_en));
		check_alg("lfo_freq", lfo_freq, exp_lfo_freq);
		check_tmra("value_a", value_a, exp_value_a);
		check_byte("value_b", value_b, exp_value_b);
		check_byte("en_irq_a", byte_t'(en_irq_a), byte_t'(exp_irq_a));
		check_byte("en_irq_b", byte_t'(en_irq_b), byte_t'(exp_irq_b));
		check_byte("load_a pulses", byte_t'(ld_a_cnt), byte_t'(exp_ld_a));
		check_byte("load_b pulses", byte_t'(ld_b_cnt), byte_t'(exp_ld_b));
		check_byte("clr_a pulses", byte_t'(clr_a_cnt), byte_t'(exp_clr_a));
		check_byte("clr_b pulses", byte_t'(clr_b_cnt), byte_t'(exp_clr_b));
		check_byte("keyon pulses", byte_t'(kon_cnt), byte_t'(exp_kon_cnt));
		check_alg("keyon_ch", kon_ch_seen, exp_kon_ch);
		check_byte("keyon_ops", byte_t'(kon_ops_seen), byte_t'(exp_kon_ops));
	endtask

	task automatic check_store();
		int idx;
		for (int c = 0; c < NUM_CH; c++) begin
			for (int o = 0; o < 4; o++) begin
				idx = c * 4 + o;
				@(posedge clk);
				#1;
				rd_ch = ch_t'(c);
				rd_op = op_t'(o);
				@(negedge clk);
				check_tl($sformatf("rd_tl[%0d]", idx), rd_tl, exp_tl[idx]);
				check_byte($sformatf("rd_mul[%0d]", idx), byte_t'(rd_mul), byte_t'(exp_mul[idx]));
				if (o == 0) begin
					check_fnum($sformatf("rd_fnum[%0d]", c), rd_fnum, exp_fnum[c]);
					check_alg($sformatf("rd_block[%0d]", c), rd_block, exp_blk[c]);
					check_alg($sformatf("rd_alg[%0d]", c), rd_alg, exp_alg[c]);
					check_alg($sformatf("rd_fb[%0d]", c), rd_fb, exp_fb[c]);
				end
			end
		end
	endtask

	initial begin
		#1000000;
		$display("simulation time limit reached before the test sequence ended");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int ch;
		byte_t regno;
		seed = 5065;
		errors = 0;
		timeouts = 0;
		data_sent = 0;
		rst = 1'b1;
		cen = 1'b1;
		write = 1'b0;
		addr = '0;
		din = '0;
		rd_ch = '0;
		rd_op = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			exp_fnum[i] = '0;
			exp_blk[i] = '0;
			exp_fhi[i] = '0;
			exp_alg[i] = '0;
			exp_fb[i] = '0;
		end
		for (int i = 0; i < NUM_OP; i++) begin
			exp_tl[i] = '0;
			exp_mul[i] = '0;
		end
		{exp_lfo_en, exp_lfo_freq, exp_irq_a, exp_irq_b} = '0;
		exp_value_a = '0;
		exp_value_b = '0;
		{exp_ld_a, exp_ld_b, exp_clr_a, exp_clr_b, exp_kon_cnt} = '0;
		exp_kon_ch = '0;
		exp_kon_ops = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// divide by 6 out of reset
		measure_period(8'd6);
		measure_period(8'd6);

		for (int i = 0; i < NUM_ROWS; i++) begin
			issue_row(rows[i].bank, rows[i].regno, rows[i].data);
			if (rows[i].wait_idle) begin
				wait_idle();
				check_globals();
				check_store();
			end
		end

		// total level then multiplier for every operator slot
		for (int c = 0; c < NUM_CH; c++) begin
			for (int o = 0; o < 4; o++) begin
				regno = TL + byte_t'(o * 4 + c % 3);
				issue_row(c >= 3, regno, byte_t'($random(seed)));
				wait_idle();
				regno = DT_MUL + byte_t'(o * 4 + c % 3);
				issue_row(c >= 3, regno, byte_t'($random(seed)));
				wait_idle();
			end
		end
		check_store();

		// 16 queue words back to back
		for (int i = 0; i < 8; i++) begin
			ch = $unsigned($random(seed)) % NUM_CH;
			issue_row(ch >= 3, FB_ALG + byte_t'(ch % 3), byte_t'($random(seed)));
		end
		wait_idle();
		check_globals();
		check_store();

		issue_row(1'b0, REG_CLK_N3, 8'h00);
		wait_idle();
		measure_period(8'd3);
		measure_period(8'd3);
		issue_row(1'b0, REG_CLK_N2, 8'h00);
		wait_idle();
		measure_period(8'd2);
		measure_period(8'd2);

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fm_regs_top.f
hdl/fm_pkg.sv
hdl/fm_cen_div.sv
hdl/fm_write_queue.sv
hdl/fm_mmr_decode.sv
hdl/fm_reg_store.sv
hdl/fm_regs_top.sv
dv/fm_regs_tb.sv
